// ==== common/pm_defs.svh ====
/*
 * Process monitor parameters.
 * Monitor count, field widths and the ring oscillator rate rule.
 */
`ifndef PM_DEFS_SVH
`define PM_DEFS_SVH

// Monitor count and field widths
`define PM_NB_MONITOR   8
`define PM_TARGET_W     12
`define PM_COUNT_W      16
`define PM_PHASE_W      8
`define PM_IDX_W        3

// Rate of monitor k is BASE + k * STEP on an 8-bit phase
`define PM_RO_RATE_BASE 37
`define PM_RO_RATE_STEP 23

`endif

// ==== common/pm_pkg.sv ====
/*
 * Process monitor types.
 * Vector types, configuration and TDR structs, window state.
 */
`default_nettype none

`include "pm_defs.svh"

package pm_pkg;

  typedef logic [`PM_TARGET_W-1:0]   pm_target_t;
  typedef logic [`PM_NB_MONITOR-1:0] pm_ro_mask_t;
  typedef logic [`PM_COUNT_W-1:0]    pm_count_t;
  typedef logic [`PM_NB_MONITOR-1:0][`PM_COUNT_W-1:0] pm_counts_t;
  typedef logic [`PM_IDX_W-1:0]      pm_mon_idx_t;

  typedef struct packed {
    logic        enable;
    pm_target_t  target;
    pm_ro_mask_t use_ro;
  } pm_cfg_t;

  typedef struct packed {
    logic        jtag_mode;
    pm_cfg_t     cfg;
    pm_mon_idx_t read_idx;
  } pm_tdr_ctrl_t;

  // Count sits at the bottom so it leaves on tdo first
  typedef struct packed {
    pm_tdr_ctrl_t ctrl;
    logic         result_valid;
    pm_count_t    result_count;
  } pm_tdr_t;

  typedef enum logic [1:0] {
    PM_IDLE,
    PM_RUN,
    PM_DONE
  } pm_win_state_e;

endpackage

`default_nettype wire

// ==== jtag_tdr/pm_jtag_tdr.sv ====
/*
 * Process monitor JTAG test data register.
 * Capture, shift and update on i_clk, with a shadow control
 * register feeding the decode block.
 */
`timescale 1ns/10ps
`default_nettype none

module pm_jtag_tdr (
  input  wire                     i_clk,
  input  wire                     i_reset,
  input  wire                     i_sel,
  input  wire                     i_capture,
  input  wire                     i_shift,
  input  wire                     i_update,
  input  wire                     i_tdi,
  input  wire                     i_valid,
  input  wire pm_pkg::pm_counts_t i_counts,
  output logic                    o_tdo,
  output pm_pkg::pm_tdr_ctrl_t    o_ctrl
);
  import pm_pkg::*;

  localparam int unsigned TDR_W = $bits(pm_tdr_t);

  pm_tdr_t      tdr_q;
  pm_tdr_ctrl_t shadow_q;
  pm_count_t    sel_count;

  // Readback monitor chosen by the active control
  assign sel_count = i_counts[shadow_q.read_idx];

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      tdr_q <= '0;
    end else if (i_sel) begin
      if (i_capture) begin
        tdr_q.result_valid <= i_valid;
        tdr_q.result_count <= sel_count;
      end else if (i_shift) begin
        tdr_q <= {i_tdi, tdr_q[TDR_W-1:1]};
      end
    end
  end

  // Update only when no higher priority strobe is present
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      shadow_q <= '0;
    end else if (i_sel && i_update && !i_capture && !i_shift) begin
      shadow_q <= tdr_q.ctrl;
    end
  end

  assign o_tdo  = tdr_q[0];
  assign o_ctrl = shadow_q;

endmodule

`default_nettype wire

// ==== logic/pm_ctrl_decode.sv ====
/*
 * Process monitor control decode.
 * Picks JTAG or functional configuration, latches it on a rising
 * enable and issues the start and clear pulses.
 */
`timescale 1ns/10ps
`default_nettype none

module pm_ctrl_decode (
  input  wire                  i_clk,
  input  wire                  i_reset,
  input  wire                  i_enable,
  input  wire pm_pkg::pm_target_t   i_target,
  input  wire pm_pkg::pm_ro_mask_t  i_use_ro,
  input  wire pm_pkg::pm_tdr_ctrl_t i_jtag_ctrl,
  output pm_pkg::pm_cfg_t      o_cfg,
  output logic                 o_start,
  output logic                 o_clear
);
  import pm_pkg::*;

  pm_cfg_t func_cfg;
  pm_cfg_t sel_cfg;
  logic    enable_q;
  logic    enable_rise;
  logic    enable_fall;

  always_comb begin
    func_cfg.enable = i_enable;
    func_cfg.target = i_target;
    func_cfg.use_ro = i_use_ro;
  end

  // Shadow register takes over in JTAG mode
  assign sel_cfg = i_jtag_ctrl.jtag_mode ? i_jtag_ctrl.cfg : func_cfg;

  assign enable_rise = sel_cfg.enable & ~enable_q;
  assign enable_fall = ~sel_cfg.enable & enable_q;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      enable_q <= 1'b0;
      o_start  <= 1'b0;
      o_clear  <= 1'b0;
      o_cfg    <= '0;
    end else begin
      enable_q <= sel_cfg.enable;
      o_start  <= enable_rise;
      o_clear  <= enable_rise | enable_fall;
      // Config frozen for the whole window
      if (enable_rise) begin
        o_cfg <= sel_cfg;
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/pm_result.sv ====
/*
 * Process monitor result register.
 * Holds published counts and the valid level between windows.
 */
`timescale 1ns/10ps
`default_nettype none

module pm_result (
  input  wire                     i_clk,
  input  wire                     i_reset,
  input  wire pm_pkg::pm_counts_t i_counts,
  input  wire                     i_done,
  input  wire                     i_clear,
  output pm_pkg::pm_counts_t      o_counts,
  output logic                    o_valid
);
  import pm_pkg::*;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_counts <= '0;
      o_valid  <= 1'b0;
    end else begin
      if (i_done) begin
        o_counts <= i_counts;
      end
      // Clear wins so a stale window never shows as valid
      if (i_clear) begin
        o_valid <= 1'b0;
      end else if (i_done) begin
        o_valid <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/process_monitor_top.sv ====
/*
 * Process monitor top level.
 * JTAG TDR, control decode, oscillator array and result register.
 */
`timescale 1ns/10ps
`default_nettype none

module process_monitor_top (
  input  wire                      i_clk,
  input  wire                      i_reset,
  input  wire                      i_enable,
  input  wire pm_pkg::pm_target_t  i_target,
  input  wire pm_pkg::pm_ro_mask_t i_use_ro,
  input  wire                      i_tdr_sel,
  input  wire                      i_tdr_capture,
  input  wire                      i_tdr_shift,
  input  wire                      i_tdr_update,
  input  wire                      i_tdi,
  output logic                     o_tdo,
  output logic                     o_valid,
  output pm_pkg::pm_counts_t       o_count
);
  import pm_pkg::*;

  pm_tdr_ctrl_t jtag_ctrl;
  pm_cfg_t      run_cfg;
  logic         start;
  logic         clear;
  pm_counts_t   ro_counts;
  logic         done;

  pm_jtag_tdr u_tdr (
    .i_clk    (i_clk),
    .i_reset  (i_reset),
    .i_sel    (i_tdr_sel),
    .i_capture(i_tdr_capture),
    .i_shift  (i_tdr_shift),
    .i_update (i_tdr_update),
    .i_tdi    (i_tdi),
    .i_valid  (o_valid),
    .i_counts (o_count),
    .o_tdo    (o_tdo),
    .o_ctrl   (jtag_ctrl)
  );

  pm_ctrl_decode u_decode (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_enable   (i_enable),
    .i_target   (i_target),
    .i_use_ro   (i_use_ro),
    .i_jtag_ctrl(jtag_ctrl),
    .o_cfg      (run_cfg),
    .o_start    (start),
    .o_clear    (clear)
  );

  pm_ro_array u_ro_array (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .i_cfg   (run_cfg),
    .i_start (start),
    .o_counts(ro_counts),
    .o_done  (done)
  );

  pm_result u_result (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .i_counts(ro_counts),
    .i_done  (done),
    .i_clear (clear),
    .o_counts(o_count),
    .o_valid (o_valid)
  );

endmodule

`default_nettype wire

// ==== monitor/pm_ro_array.sv ====
/*
 * Ring oscillator monitor array.
 * Window FSM plus one behavioral phase accumulator and edge
 * counter per monitor.
 */
`timescale 1ns/10ps
`default_nettype none

`include "pm_defs.svh"

module pm_ro_array (
  input  wire                  i_clk,
  input  wire                  i_reset,
  input  wire pm_pkg::pm_cfg_t i_cfg,
  input  wire                  i_start,
  output pm_pkg::pm_counts_t   o_counts,
  output logic                 o_done
);
  import pm_pkg::*;

  pm_win_state_e state_q;
  pm_target_t    win_cnt_q;
  logic          win_active;

  // Counting cycles of the window, target of them in total
  assign win_active = (state_q == PM_RUN) && (win_cnt_q != i_cfg.target);

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      state_q   <= PM_IDLE;
      win_cnt_q <= '0;
    end else if (i_start) begin
      // Also restarts a running window
      state_q   <= PM_RUN;
      win_cnt_q <= '0;
    end else begin
      case (state_q)
        PM_RUN: begin
          if (win_active) begin
            win_cnt_q <= win_cnt_q + 1'b1;
          end else begin
            state_q <= PM_DONE;
          end
        end
        PM_DONE: state_q <= PM_IDLE;
        default: state_q <= PM_IDLE;
      endcase
    end
  end

  // DONE lasts a single cycle
  assign o_done = (state_q == PM_DONE);

  for (genvar k = 0; k < `PM_NB_MONITOR; k++) begin : g_ro
    localparam int unsigned RATE = `PM_RO_RATE_BASE + k * `PM_RO_RATE_STEP;

    logic [`PM_PHASE_W-1:0] phase_q;
    logic [`PM_PHASE_W:0]   phase_sum;
    pm_count_t              count_q;

    // Carry out of the phase is one oscillator edge
    assign phase_sum = {1'b0, phase_q} + (`PM_PHASE_W + 1)'(RATE);

    always_ff @(posedge i_clk) begin
      if (i_start) begin
        phase_q <= '0;
        count_q <= '0;
      end else if (win_active && i_cfg.enable && i_cfg.use_ro[k]) begin
        phase_q <= phase_sum[`PM_PHASE_W-1:0];
        count_q <= count_q + pm_count_t'(phase_sum[`PM_PHASE_W]);
      end
    end

    assign o_counts[k] = count_q;
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+common
common/pm_pkg.sv
jtag_tdr/pm_jtag_tdr.sv
logic/pm_ctrl_decode.sv
monitor/pm_ro_array.sv
logic/pm_result.sv
logic/process_monitor_top.sv
tests/tb_process_monitor.sv

// ==== tests/pm_testdata.txt ====
# mode target(hex) use_ro(hex) read_idx expected_count(decimal)
# mode F uses the functional inputs, mode J loads the configuration through the TDR
F 064 ff 3 41
F fff ff 7 3167
F 0c8 a5 5 118
F 0c8 a5 1 0
F 000 ff 4 0
J 1f4 3c 2 162
J 07b 81 0 17
J 0ff 81 6 0
F 00a 80 7 7
J 800 ff 4 1032
F 3e8 5a 6 683
J 000 ff 2 0

// ==== tests/tb_process_monitor.sv ====
/*
 * Process monitor testbench.
 * Runs testdata records through the functional inputs or the JTAG TDR
 * and checks the counts, the valid level and the TDR readback.
 */
`timescale 1ns/10ps
`default_nettype none

`include "pm_defs.svh"

module tb_process_monitor;
  import pm_pkg::*;

  localparam int TDR_W    = $bits(pm_tdr_t);
  localparam int CLK_HALF = 20;

  logic        i_clk = 1'b0;
  logic        i_reset;
  logic        i_enable;
  pm_target_t  i_target;
  pm_ro_mask_t i_use_ro;
  logic        i_tdr_sel;
  logic        i_tdr_capture;
  logic        i_tdr_shift;
  logic        i_tdr_update;
  logic        i_tdi;
  logic        o_tdo;
  logic        o_valid;
  pm_counts_t  o_count;

  logic        rec_jtag[$];
  pm_target_t  rec_target[$];
  pm_ro_mask_t rec_mask[$];
  pm_mon_idx_t rec_idx[$];
  pm_count_t   rec_exp[$];
  logic        records_read = 1'b0;

  process_monitor_top u_process_monitor_top (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_enable     (i_enable),
    .i_target     (i_target),
    .i_use_ro     (i_use_ro),
    .i_tdr_sel    (i_tdr_sel),
    .i_tdr_capture(i_tdr_capture),
    .i_tdr_shift  (i_tdr_shift),
    .i_tdr_update (i_tdr_update),
    .i_tdi        (i_tdi),
    .o_tdo        (o_tdo),
    .o_valid      (o_valid),
    .o_count      (o_count)
  );

  always #CLK_HALF i_clk = ~i_clk;

  task automatic abort_run();
    $display("STATUS: FAIL");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic check_count(input string name, input pm_count_t got, input pm_count_t exp);
    if (got !== exp) begin
      $display("FAILED time=%0t %s got=%0d expected=%0d", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED time=%0t %s got=%b expected=%b", $time, name, got, exp);
      abort_run();
    end
  endtask

  // Carries of an 8-bit phase stepped by the monitor rate
  function automatic pm_count_t expected_count(input pm_target_t target,
                                               input pm_ro_mask_t mask, input int k);
    int unsigned rate;
    int unsigned product;
    rate    = `PM_RO_RATE_BASE + k * `PM_RO_RATE_STEP;
    product = target * rate;
    if (mask[k]) begin
      return pm_count_t'(product >> `PM_PHASE_W);
    end else begin
      return '0;
    end
  endfunction

  function automatic pm_tdr_ctrl_t make_ctrl(input logic jtag, input logic enable,
                                             input pm_target_t target,
                                             input pm_ro_mask_t mask, input pm_mon_idx_t idx);
    return {jtag, enable, target, mask, idx};
  endfunction

  task automatic compare_all_monitors(input pm_target_t target, input pm_ro_mask_t mask);
    for (int k = 0; k < `PM_NB_MONITOR; k++) begin
      check_count($sformatf("o_count[%0d]", k), o_count[k], expected_count(target, mask, k));
    end
  endtask

  // LSB first, then update into the shadow register
  task automatic shift_in_ctrl(input pm_tdr_ctrl_t ctrl);
    pm_tdr_t          word;
    logic [TDR_W-1:0] bits;
    word      = '0;
    word.ctrl = ctrl;
    bits      = word;
    for (int i = 0; i < TDR_W; i++) begin
      @(negedge i_clk);
      i_tdr_sel   = 1'b1;
      i_tdr_shift = 1'b1;
      i_tdi       = bits[i];
    end
    @(negedge i_clk);
    i_tdr_shift  = 1'b0;
    i_tdr_update = 1'b1;
    @(negedge i_clk);
    i_tdr_update = 1'b0;
    i_tdr_sel    = 1'b0;
    i_tdi        = 1'b0;
  endtask

  task automatic capture_readback(output pm_count_t count, output logic valid);
    pm_tdr_t          word;
    logic [TDR_W-1:0] bits;
    @(negedge i_clk);
    i_tdr_sel     = 1'b1;
    i_tdr_capture = 1'b1;
    for (int i = 0; i < TDR_W; i++) begin
      @(negedge i_clk);
      i_tdr_capture = 1'b0;
      bits[i]       = o_tdo;
      i_tdr_shift   = 1'b1;
      i_tdi         = 1'b0;
    end
    @(negedge i_clk);
    i_tdr_shift = 1'b0;
    i_tdr_sel   = 1'b0;
    word  = bits;
    count = word.result_count;
    valid = word.result_valid;
  endtask

  // Bounded by the watchdog
  task automatic wait_valid(input logic level);
    while (o_valid !== level) begin
      @(negedge i_clk);
    end
  endtask

  initial begin
    longint limit_ns;
    wait (records_read);
    limit_ns = longint'(rec_target.size()) * (2 ** `PM_TARGET_W + 200) * (2 * CLK_HALF);
    #(limit_ns);
    $display("ERROR: watchdog expired after %0d ns, o_valid never arrived", limit_ns);
    abort_run();
  end

  initial begin
    int               fd;
    int               n;
    int               v_target;
    int               v_mask;
    int               v_idx;
    int               v_exp;
    logic [8*8-1:0]   tok;
    logic [8*128-1:0] skip;
    logic             jtag;
    pm_target_t       tgt;
    pm_ro_mask_t      mask;
    pm_mon_idx_t      idx;
    pm_count_t        rd_count;
    logic             rd_valid;

    i_reset       = 1'b1;
    i_enable      = 1'b0;
    i_target      = '0;
    i_use_ro      = '0;
    i_tdr_sel     = 1'b0;
    i_tdr_capture = 1'b0;
    i_tdr_shift   = 1'b0;
    i_tdr_update  = 1'b0;
    i_tdi         = 1'b0;

    fd = $fopen("tests/pm_testdata.txt", "r");
    if (fd == 0) begin
      $display("ERROR: cannot open tests/pm_testdata.txt");
      abort_run();
    end
    while ($fscanf(fd, "%s", tok) == 1) begin
      if (tok == "#") begin
        n = $fgets(skip, fd);
      end else begin
        n = $fscanf(fd, "%h %h %d %d", v_target, v_mask, v_idx, v_exp);
        if (n != 4 || (tok != "F" && tok != "J")) begin
          $display("ERROR: malformed record in tests/pm_testdata.txt");
          abort_run();
        end
        rec_jtag.push_back(tok == "J");
        rec_target.push_back(pm_target_t'(v_target));
        rec_mask.push_back(pm_ro_mask_t'(v_mask));
        rec_idx.push_back(pm_mon_idx_t'(v_idx));
        rec_exp.push_back(pm_count_t'(v_exp));
      end
    end
    $fclose(fd);
    if (rec_target.size() == 0) begin
      $display("ERROR: no records found in tests/pm_testdata.txt");
      abort_run();
    end
    records_read = 1'b1;

    repeat (3) @(posedge i_clk);
    @(negedge i_clk);
    i_reset = 1'b0;
    check_flag("o_valid", o_valid, 1'b0);
    check_flag("o_tdo", o_tdo, 1'b0);
    compare_all_monitors('0, '0);

    for (int r = 0; r < rec_target.size(); r++) begin
      jtag = rec_jtag[r];
      tgt  = rec_target[r];
      mask = rec_mask[r];
      idx  = rec_idx[r];
      check_count($sformatf("testdata record %0d count", r), rec_exp[r],
                  expected_count(tgt, mask, idx));

      if (jtag) begin
        // Source and readback index first, enable still low
        shift_in_ctrl(make_ctrl(1'b1, 1'b0, tgt, mask, idx));
        // Functional inputs disagree with the TDR on purpose
        @(negedge i_clk);
        i_enable = 1'b1;
        i_target = ~tgt;
        i_use_ro = ~mask;
        shift_in_ctrl(make_ctrl(1'b1, 1'b1, tgt, mask, idx));
      end else begin
        // Shadow holds a conflicting configuration that must stay unused
        shift_in_ctrl(make_ctrl(1'b0, 1'b1, ~tgt, ~mask, idx));
        @(negedge i_clk);
        i_target = tgt;
        i_use_ro = mask;
        i_enable = 1'b1;
      end
      wait_valid(1'b1);
      compare_all_monitors(tgt, mask);

      capture_readback(rd_count, rd_valid);
      check_count("o_tdo count field", rd_count, expected_count(tgt, mask, idx));
      check_flag("o_tdo valid field", rd_valid, 1'b1);

      if (jtag) begin
        shift_in_ctrl(make_ctrl(1'b1, 1'b0, tgt, mask, idx));
      end else begin
        @(negedge i_clk);
        i_enable = 1'b0;
      end
      wait_valid(1'b0);
      compare_all_monitors(tgt, mask);
      @(negedge i_clk);
      i_enable = 1'b0;
    end

    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire
